//--- design/axi_mid_pkg.sv
// shared axi mid-path types and defaults; addresses count words, single requester, no ids
`default_nettype none

package axi_mid_pkg;

  // ------------------------------------------------------------------------
  // channel field types
  // ------------------------------------------------------------------------
  typedef logic [7:0] len_t;                    // burst length minus one
  typedef logic [1:0] resp_t;                   // axi response code

  localparam resp_t RESP_OKAY   = 2'b00;        // normal completion
  localparam resp_t RESP_SLVERR = 2'b10;        // slave error, out of range burst

  // ------------------------------------------------------------------------
  // default sizes picked up by the top level
  // ------------------------------------------------------------------------
  localparam int DATA_W_DEF    = 32;            // word width in bits
  localparam int ADDR_W_DEF    = 16;            // word address width
  localparam int MEM_WORDS_DEF = 256;           // on-chip memory depth

endpackage : axi_mid_pkg

`default_nettype wire

//--- design/axi_mid_if.sv
// reduced axi4 bus: no id, strobe, size, burst type or cache fields; full words only
`timescale 1ns/10ps
`default_nettype none

interface axi_mid_if
  import axi_mid_pkg::*;
#(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 16
);

  // ------------------------------------------------------------------------
  // read channels
  // ------------------------------------------------------------------------
  logic              arvalid;                   // read address valid
  logic              arready;
  logic [ADDR_W-1:0] araddr;                    // first word of the burst
  len_t              arlen;

  logic              rvalid;                    // read data valid
  logic              rready;
  logic [DATA_W-1:0] rdata;
  resp_t             rresp;
  logic              rlast;                     // final beat of the burst

  // ------------------------------------------------------------------------
  // write channels
  // ------------------------------------------------------------------------
  logic              awvalid;                   // write address valid
  logic              awready;
  logic [ADDR_W-1:0] awaddr;
  len_t              awlen;

  logic              wvalid;                    // write data valid
  logic              wready;
  logic [DATA_W-1:0] wdata;
  logic              wlast;

  logic              bvalid;                    // write response valid
  logic              bready;
  resp_t             bresp;

  modport master (
    output arvalid, araddr, arlen, rready, awvalid, awaddr, awlen,
    output wvalid, wdata, wlast, bready,
    input  arready, rvalid, rdata, rresp, rlast, awready, wready, bvalid, bresp
  );

  modport slave (
    input  arvalid, araddr, arlen, rready, awvalid, awaddr, awlen,
    input  wvalid, wdata, wlast, bready,
    output arready, rvalid, rdata, rresp, rlast, awready, wready, bvalid, bresp
  );

endinterface : axi_mid_if

`default_nettype wire

//--- design/axi_skid_slice.sv
// one registered valid/ready stage, one cycle latency, full rate; in_ready low while in reset
`timescale 1ns/10ps
`default_nettype none

module axi_skid_slice #(
  parameter int WIDTH = 32
) (
  input  wire logic             ap_clk,
  input  wire logic             rst_n,
  input  wire logic             in_valid,
  output logic                  in_ready,
  input  wire logic [WIDTH-1:0] in_data,
  output logic                  out_valid,
  input  wire logic             out_ready,
  output logic      [WIDTH-1:0] out_data
);

  logic             main_valid, main_valid_nxt;  // output register occupied
  logic             skid_valid, skid_valid_nxt;  // overflow register occupied
  logic [WIDTH-1:0] skid_data;
  logic             in_take;                     // beat accepted this cycle
  logic             advance;                     // main register may load

  assign in_take   = in_valid && in_ready;
  assign advance   = out_ready || !main_valid;   // empty or draining
  assign out_valid = main_valid;

  always_comb begin
    main_valid_nxt = main_valid;
    skid_valid_nxt = skid_valid;
    if (advance) begin
      main_valid_nxt = skid_valid || in_take;    // skid drains first
      skid_valid_nxt = 1'b0;
    end else if (in_take) begin
      skid_valid_nxt = 1'b1;                     // catch the beat in flight
    end
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;                        // hold off until out of reset
    end else begin
      main_valid <= main_valid_nxt;
      skid_valid <= skid_valid_nxt;
      in_ready   <= !skid_valid_nxt;             // registered ready
    end
  end

  always_ff @(posedge ap_clk) begin
    if (in_take) skid_data <= in_data;           // harmless when main takes it
    if (advance) out_data <= skid_valid ? skid_data : in_data;
  end

endmodule : axi_skid_slice

`default_nettype wire

//--- design/axi_register_slice_mid.sv
// one stage per axi channel, +1 cycle each; stages held in reset 2 clocks after arst_n rises
`timescale 1ns/10ps
`default_nettype none

module axi_register_slice_mid
  import axi_mid_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  wire logic ap_clk,
  input  wire logic arst_n,
  axi_mid_if.slave  s_axi,                       // from the requester
  axi_mid_if.master m_axi                        // toward the memory
);

  localparam int A_W = ADDR_W + $bits(len_t);             // addr + len
  localparam int R_W = DATA_W + $bits(resp_t) + 1;        // data + resp + last
  localparam int W_W = DATA_W + 1;                        // data + last
  localparam int B_W = $bits(resp_t);

  logic [1:0]     rst_sync;                      // two-flop reset synchronizer
  logic           slice_rst_n;
  logic [A_W-1:0] ar_out, aw_out;
  logic [R_W-1:0] r_out;
  logic [W_W-1:0] w_out;
  logic [B_W-1:0] b_out;

  // ------------------------------------------------------------------------
  // local reset, asserts at once, releases on the clock
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) rst_sync <= 2'b00;
    else         rst_sync <= {rst_sync[0], 1'b1};
  end
  assign slice_rst_n = rst_sync[1];

  // ------------------------------------------------------------------------
  // forward channels ar, aw, w
  // ------------------------------------------------------------------------
  axi_skid_slice #(.WIDTH(A_W)) i_ar_slice (
    .ap_clk, .rst_n(slice_rst_n),
    .in_valid(s_axi.arvalid), .in_ready(s_axi.arready),
    .in_data({s_axi.araddr, s_axi.arlen}),
    .out_valid(m_axi.arvalid), .out_ready(m_axi.arready), .out_data(ar_out)
  );
  assign {m_axi.araddr, m_axi.arlen} = ar_out;

  axi_skid_slice #(.WIDTH(A_W)) i_aw_slice (
    .ap_clk, .rst_n(slice_rst_n),
    .in_valid(s_axi.awvalid), .in_ready(s_axi.awready),
    .in_data({s_axi.awaddr, s_axi.awlen}),
    .out_valid(m_axi.awvalid), .out_ready(m_axi.awready), .out_data(aw_out)
  );
  assign {m_axi.awaddr, m_axi.awlen} = aw_out;

  axi_skid_slice #(.WIDTH(W_W)) i_w_slice (
    .ap_clk, .rst_n(slice_rst_n),
    .in_valid(s_axi.wvalid), .in_ready(s_axi.wready),
    .in_data({s_axi.wdata, s_axi.wlast}),
    .out_valid(m_axi.wvalid), .out_ready(m_axi.wready), .out_data(w_out)
  );
  assign {m_axi.wdata, m_axi.wlast} = w_out;

  // ------------------------------------------------------------------------
  // return channels r, b
  // ------------------------------------------------------------------------
  axi_skid_slice #(.WIDTH(R_W)) i_r_slice (
    .ap_clk, .rst_n(slice_rst_n),
    .in_valid(m_axi.rvalid), .in_ready(m_axi.rready),
    .in_data({m_axi.rdata, m_axi.rresp, m_axi.rlast}),
    .out_valid(s_axi.rvalid), .out_ready(s_axi.rready), .out_data(r_out)
  );
  assign {s_axi.rdata, s_axi.rresp, s_axi.rlast} = r_out;

  axi_skid_slice #(.WIDTH(B_W)) i_b_slice (
    .ap_clk, .rst_n(slice_rst_n),
    .in_valid(m_axi.bvalid), .in_ready(m_axi.bready),
    .in_data(m_axi.bresp),
    .out_valid(s_axi.bvalid), .out_ready(s_axi.bready), .out_data(b_out)
  );
  assign s_axi.bresp = b_out;

endmodule : axi_register_slice_mid

`default_nettype wire

//--- design/burst_requester.sv
// one command at a time; write beat i carries seed+i; cmd_error valid only with cmd_done
`timescale 1ns/10ps
`default_nettype none

module burst_requester
  import axi_mid_pkg::*;
#(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  wire logic              ap_clk,
  input  wire logic              arst_n,
  input  wire logic              cmd_valid,
  output logic                   cmd_ready,
  input  wire logic              cmd_write,      // 1 write, 0 read
  input  wire logic [ADDR_W-1:0] cmd_addr,
  input  wire len_t              cmd_len,
  input  wire logic [DATA_W-1:0] cmd_seed,
  output logic                   cmd_done,       // one-cycle end pulse
  output logic                   cmd_error,
  output logic                   rd_valid,
  input  wire logic              rd_ready,
  output logic      [DATA_W-1:0] rd_data,
  output logic                   rd_last,
  axi_mid_if.master              m_axi
);

  typedef enum logic [2:0] {
    S_IDLE, S_ADDR, S_WDATA, S_WRESP, S_RDATA
  } req_state_t;

  req_state_t        state;
  logic              write_q;                    // captured command
  logic [ADDR_W-1:0] addr_q;
  len_t              len_q;
  logic [DATA_W-1:0] seed_q;
  len_t              beat_q;                     // write beat index
  logic              err_q;                      // any bad rresp so far
  logic              r_take, w_take, b_take;
  logic              r_bad;

  // ------------------------------------------------------------------------
  // bus drive, all from state and captured command
  // ------------------------------------------------------------------------
  assign cmd_ready     = (state == S_IDLE);
  assign m_axi.awvalid = (state == S_ADDR) && write_q;
  assign m_axi.arvalid = (state == S_ADDR) && !write_q;
  assign m_axi.awaddr  = addr_q;
  assign m_axi.araddr  = addr_q;
  assign m_axi.awlen   = len_q;
  assign m_axi.arlen   = len_q;
  assign m_axi.wvalid  = (state == S_WDATA);
  assign m_axi.wdata   = seed_q + DATA_W'(beat_q);
  assign m_axi.wlast   = (beat_q == len_q);
  assign m_axi.bready  = (state == S_WRESP);
  assign m_axi.rready  = (state == S_RDATA) && rd_ready;   // rd port stalls the read path

  assign rd_valid = (state == S_RDATA) && m_axi.rvalid;
  assign rd_data  = m_axi.rdata;
  assign rd_last  = m_axi.rlast;

  assign w_take = m_axi.wvalid && m_axi.wready;
  assign b_take = m_axi.bvalid && m_axi.bready;
  assign r_take = m_axi.rvalid && m_axi.rready;
  assign r_bad  = (m_axi.rresp != RESP_OKAY);

  // ------------------------------------------------------------------------
  // fsm
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      beat_q    <= '0;
      err_q     <= 1'b0;
      cmd_done  <= 1'b0;
      cmd_error <= 1'b0;
    end else begin
      cmd_done  <= 1'b0;                         // pulse defaults
      cmd_error <= 1'b0;
      case (state)
        S_IDLE: if (cmd_valid) begin
          state  <= S_ADDR;
          beat_q <= '0;
          err_q  <= 1'b0;
        end
        S_ADDR: begin
          if (m_axi.awvalid && m_axi.awready)      state <= S_WDATA;
          else if (m_axi.arvalid && m_axi.arready) state <= S_RDATA;
        end
        S_WDATA: if (w_take) begin
          beat_q <= beat_q + 1'b1;
          if (m_axi.wlast) state <= S_WRESP;
        end
        S_WRESP: if (b_take) begin
          state     <= S_IDLE;
          cmd_done  <= 1'b1;
          cmd_error <= (m_axi.bresp != RESP_OKAY);
        end
        S_RDATA: if (r_take) begin
          err_q <= err_q || r_bad;
          if (m_axi.rlast) begin                 // last beat left on rd port
            state     <= S_IDLE;
            cmd_done  <= 1'b1;
            cmd_error <= err_q || r_bad;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (cmd_valid && cmd_ready) begin            // command payload
      write_q <= cmd_write;
      addr_q  <= cmd_addr;
      len_q   <= cmd_len;
      seed_q  <= cmd_seed;
    end
  end

endmodule : burst_requester

`default_nettype wire

//--- design/burst_memory.sv
// one burst at a time, aw before ar; needs 2**ADDR_W >= MEM_WORDS; ram has no reset
`timescale 1ns/10ps
`default_nettype none

module burst_memory
  import axi_mid_pkg::*;
#(
  parameter int DATA_W    = DATA_W_DEF,
  parameter int ADDR_W    = ADDR_W_DEF,
  parameter int MEM_WORDS = MEM_WORDS_DEF
) (
  input  wire logic ap_clk,
  input  wire logic arst_n,
  axi_mid_if.slave  s_axi
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int END_W = ADDR_W + 2;             // room for addr + len + 1

  typedef enum logic [1:0] {
    M_IDLE, M_WDATA, M_BRESP, M_RDATA
  } mem_state_t;

  mem_state_t        state;
  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [ADDR_W-1:0] addr_q;                     // current word
  len_t              len_q;
  len_t              cnt_q;                      // read beat index
  logic              oob_q;                      // burst is out of range
  logic [ADDR_W-1:0] req_addr;
  len_t              req_len;
  logic [END_W-1:0]  req_end;
  logic              req_oob;
  logic [IDX_W-1:0]  idx;
  logic              aw_take, ar_take, w_take, r_take;
  resp_t             resp;

  // ------------------------------------------------------------------------
  // range check on the request about to be taken
  // ------------------------------------------------------------------------
  always_comb begin
    req_addr = s_axi.awvalid ? s_axi.awaddr : s_axi.araddr;   // aw wins
    req_len  = s_axi.awvalid ? s_axi.awlen  : s_axi.arlen;
    req_end  = END_W'(req_addr) + END_W'(req_len) + 1'b1;
    req_oob  = (32'(req_end) > 32'(MEM_WORDS));
  end

  assign idx  = addr_q[IDX_W-1:0];
  assign resp = oob_q ? RESP_SLVERR : RESP_OKAY;

  assign s_axi.awready = (state == M_IDLE);
  assign s_axi.arready = (state == M_IDLE) && !s_axi.awvalid;
  assign s_axi.wready  = (state == M_WDATA);
  assign s_axi.bvalid  = (state == M_BRESP);
  assign s_axi.bresp   = resp;
  assign s_axi.rvalid  = (state == M_RDATA);
  assign s_axi.rdata   = oob_q ? '0 : mem[idx];  // zero data on error
  assign s_axi.rresp   = resp;
  assign s_axi.rlast   = (cnt_q == len_q);

  assign aw_take = s_axi.awvalid && s_axi.awready;
  assign ar_take = s_axi.arvalid && s_axi.arready;
  assign w_take  = s_axi.wvalid && s_axi.wready;
  assign r_take  = s_axi.rvalid && s_axi.rready;

  // ------------------------------------------------------------------------
  // fsm
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= M_IDLE;
      cnt_q <= '0;
    end else begin
      case (state)
        M_IDLE: begin
          cnt_q <= '0;
          if (aw_take)      state <= M_WDATA;
          else if (ar_take) state <= M_RDATA;
        end
        M_WDATA: if (w_take && s_axi.wlast) state <= M_BRESP;
        M_BRESP: if (s_axi.bready) state <= M_IDLE;
        M_RDATA: if (r_take) begin
          cnt_q <= cnt_q + 1'b1;
          if (s_axi.rlast) state <= M_IDLE;
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (aw_take || ar_take) begin                // burst header
      addr_q <= req_addr;
      len_q  <= req_len;
      oob_q  <= req_oob;
    end else if (w_take || r_take) begin
      addr_q <= addr_q + 1'b1;
    end
    if (w_take && !oob_q) mem[idx] <= s_axi.wdata;   // bad bursts leave ram alone
  end

endmodule : burst_memory

`default_nettype wire

//--- design/mem_path_top.sv
// requester -> register slice -> burst memory; word addressed, full-word writes only
`timescale 1ns/10ps
`default_nettype none

module mem_path_top
  import axi_mid_pkg::*;
#(
  parameter int DATA_W    = DATA_W_DEF,
  parameter int ADDR_W    = ADDR_W_DEF,
  parameter int MEM_WORDS = MEM_WORDS_DEF
) (
  input  wire logic              ap_clk,
  input  wire logic              arst_n,
  input  wire logic              cmd_valid,
  output logic                   cmd_ready,
  input  wire logic              cmd_write,
  input  wire logic [ADDR_W-1:0] cmd_addr,
  input  wire len_t              cmd_len,
  input  wire logic [DATA_W-1:0] cmd_seed,
  output logic                   cmd_done,
  output logic                   cmd_error,
  output logic                   rd_valid,
  input  wire logic              rd_ready,
  output logic      [DATA_W-1:0] rd_data,
  output logic                   rd_last
);

  axi_mid_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) req_bus ();   // requester side
  axi_mid_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) mem_bus ();   // memory side

  burst_requester #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_burst_requester (
    .ap_clk, .arst_n,
    .cmd_valid, .cmd_ready, .cmd_write, .cmd_addr, .cmd_len, .cmd_seed,
    .cmd_done, .cmd_error,
    .rd_valid, .rd_ready, .rd_data, .rd_last,
    .m_axi(req_bus.master)
  );

  axi_register_slice_mid #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_register_slice (
    .ap_clk, .arst_n,
    .s_axi(req_bus.slave),
    .m_axi(mem_bus.master)
  );

  burst_memory #(
    .DATA_W(DATA_W), .ADDR_W(ADDR_W), .MEM_WORDS(MEM_WORDS)
  ) i_burst_memory (
    .ap_clk, .arst_n,
    .s_axi(mem_bus.slave)
  );

endmodule : mem_path_top

`default_nettype wire

//--- test/tb_clock_gen.sv
// free-running testbench clock; starts low, first rising edge after half a period
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic ap_clk
);

  initial ap_clk = 1'b0;
  always #(PERIOD_NS / 2) ap_clk = ~ap_clk;       // 50% duty

endmodule : tb_clock_gen

`default_nettype wire

//--- test/tb_mem_path.sv
// run from the project root; the model assumes every read hits words that an earlier write set
`timescale 1ns/10ps
`default_nettype none

module tb_mem_path;

  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 16;
  localparam int MEM_WORDS  = 256;
  localparam int WAIT_LIMIT = 2000;               // cycles allowed per wait

  logic              ap_clk;
  logic              arst_n;
  logic              cmd_valid, cmd_ready, cmd_write;
  logic [ADDR_W-1:0] cmd_addr;
  logic [7:0]        cmd_len;
  logic [DATA_W-1:0] cmd_seed;
  logic              cmd_done, cmd_error;
  logic              rd_valid, rd_ready, rd_last;
  logic [DATA_W-1:0] rd_data;

  logic [DATA_W-1:0] model [MEM_WORDS];           // expected ram contents
  int                errors;
  int                checks;
  bit                timed_out;                   // a wait expired, run stops

  tb_clock_gen #(.PERIOD_NS(40)) i_clock_gen (.ap_clk);

  mem_path_top #(
    .DATA_W(DATA_W), .ADDR_W(ADDR_W), .MEM_WORDS(MEM_WORDS)
  ) i_mem_path_top (
    .ap_clk, .arst_n,
    .cmd_valid, .cmd_ready, .cmd_write, .cmd_addr, .cmd_len, .cmd_seed,
    .cmd_done, .cmd_error,
    .rd_valid, .rd_ready, .rd_data, .rd_last
  );

  // --------------------------------------------------------------------------
  // helpers, all called right after a rising edge
  // --------------------------------------------------------------------------
  task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic issue_cmd(input bit write, input logic [ADDR_W-1:0] addr,
                           input logic [7:0] len, input logic [DATA_W-1:0] seed);
    int waited;
    waited    = 0;
    cmd_valid <= 1'b1;
    cmd_write <= write;
    cmd_addr  <= addr;
    cmd_len   <= len;
    cmd_seed  <= seed;
    do begin
      @(posedge ap_clk);                          // accepted at the edge where ready is seen
      waited++;
    end while (!cmd_ready && waited < WAIT_LIMIT);
    if (!cmd_ready) begin
      $display("timeout: cmd_ready stayed low, command not accepted");
      timed_out = 1'b1;
    end
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_done(output logic err);
    int waited;
    waited = 0;
    do begin
      @(posedge ap_clk);
      waited++;
    end while (!cmd_done && waited < WAIT_LIMIT);
    if (!cmd_done) begin
      $display("timeout: cmd_done never came for the write");
      timed_out = 1'b1;
    end
    err = cmd_error;
  endtask

  task automatic collect_read(input logic [ADDR_W-1:0] addr, input logic [7:0] len,
                              input bit oob, input bit hold, output logic err);
    int                waited;
    int                beats;
    bit                done;
    logic [DATA_W-1:0] exp;
    waited   = 0;
    beats    = 0;
    done     = 1'b0;
    err      = 1'b0;
    rd_ready <= hold ? 1'b1 : 1'($urandom);
    while (!done && !timed_out) begin
      @(posedge ap_clk);
      waited++;
      if (rd_valid && rd_ready) begin             // beat moved at this edge
        exp = oob ? '0 : model[(int'(addr) + beats) % MEM_WORDS];
        check_value($sformatf("rd_data beat %0d", beats), rd_data, exp);
        check_value($sformatf("rd_last beat %0d", beats), DATA_W'(rd_last),
                    DATA_W'(beats == int'(len)));
        beats++;
        waited = 0;
      end
      if (cmd_done) begin
        done = 1'b1;
        err  = cmd_error;
      end else if (waited >= WAIT_LIMIT) begin
        if (beats <= int'(len)) $display("timeout: rd_valid never came for beat %0d", beats);
        else                    $display("timeout: cmd_done never came after the last beat");
        timed_out = 1'b1;
      end
      rd_ready <= hold ? 1'b1 : 1'($urandom);     // random back-pressure
    end
    if (done) check_value("read beat count", DATA_W'(beats), DATA_W'(int'(len) + 1));
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    int                fd;
    int                n;
    int                i;
    int                waited;
    int                line_no;
    int                tests;
    int                errors_before;
    string             line;
    string             op;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [DATA_W-1:0] seed;
    logic              exp_err;
    logic              err;
    bit                oob;

    void'($urandom(32'heb03_f707));
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    tests     = 0;
    line_no   = 0;
    waited    = 0;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_addr  = '0;
    cmd_len   = '0;
    cmd_seed  = '0;
    rd_ready  = 1'b1;

    repeat (4) @(posedge ap_clk);
    arst_n <= 1'b1;
    @(posedge ap_clk);
    check_value("rd_valid after reset", DATA_W'(rd_valid), '0);
    check_value("cmd_done after reset", DATA_W'(cmd_done), '0);
    while (!cmd_ready && waited < WAIT_LIMIT) begin
      @(posedge ap_clk);
      waited++;
    end
    if (!cmd_ready) begin
      $display("timeout: cmd_ready stayed low after reset");
      timed_out = 1'b1;
    end

    fd = $fopen("test/mem_path_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/mem_path_stimulus.txt");
      errors++;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        n = $fgets(line, fd);
        line_no++;
        if (n == 0 || line.len() < 2 || line[0] == "#") continue;   // blank or comment
        err = 1'b0;
        n   = $sscanf(line, "%s %h %h %h %h", op, addr, len, seed, exp_err);
        if (n != 5) begin
          $display("line %0d of the stimulus cannot be read", line_no);
          errors++;
          continue;
        end
        oob           = (int'(addr) + int'(len) + 1 > MEM_WORDS);
        errors_before = errors;
        issue_cmd(op == "w", addr, len, seed);
        if (op == "w") begin
          if (!timed_out) wait_done(err);
          if (!oob) begin                         // ram only changes for good bursts
            for (i = 0; i <= int'(len); i++) model[int'(addr) + i] = seed + DATA_W'(i);
          end
        end else if (!timed_out) begin
          collect_read(addr, len, oob, op == "h", err);
        end
        if (!timed_out) check_value("cmd_error", DATA_W'(err), DATA_W'(exp_err));
        tests++;
        $display("line %0d: %s addr %h len %0d %s", line_no, op, addr, len,
                 (errors == errors_before && !timed_out) ? "ok" : "failed");
      end
      $fclose(fd);
    end

    $display("%0d commands, %0d checks, %0d errors, %0d timeouts",
             tests, checks, errors, int'(timed_out));
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_mem_path

`default_nettype wire

//--- test/mem_path_stimulus.txt
# op addr len seed err : op w write, r read with random rd_ready, h read with rd_ready high
# addr, len and seed in hex; err is the expected cmd_error
w 0010 03 00001000 0
h 0010 03 00000000 0
r 0010 03 00000000 0
w 0020 0f a5a50000 0
h 0020 0f 00000000 0
r 0020 0f 00000000 0
w 0005 00 deadbeef 0
r 0005 00 00000000 0
w 00f0 0f 12340000 0
r 00f0 0f 00000000 0
w 00f8 0f 55550000 1
r 00f8 0f 00000000 1
r 00f0 0f 00000000 0
r 0100 00 00000000 1
w 0010 07 77770000 0
w 0012 01 99990000 0
w 0020 02 0badf00d 0
r 0010 07 00000000 0
h 0020 0f 00000000 0
r 00ff 00 00000000 0

//--- sim.f
design/axi_mid_pkg.sv
design/axi_mid_if.sv
design/axi_skid_slice.sv
design/axi_register_slice_mid.sv
design/burst_requester.sv
design/burst_memory.sv
design/mem_path_top.sv
test/tb_clock_gen.sv
test/tb_mem_path.sv

//--- Makefile
# Verilator build and run of the memory path testbench

SIM  := obj_dir/Vtb_mem_path
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

$(SIM): sim.f $(SRCS)
	verilator --binary -Wno-fatal --top-module tb_mem_path -f sim.f -o Vtb_mem_path

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir
